/* logic/dispatch_params.svh */
////////////////////////////////////////
// width defines for the dispatch stage
// data, register index, commit id and
// byte write mask
////////////////////////////////////////

`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// operand and address width
`define DATA_WIDTH 32

// register file index
`define REG_ADDR_WIDTH 5

// load identifier, sets the scoreboard depth
`define COMMIT_ID_WIDTH 2

// byte lanes per data word
`define WMASK_WIDTH 4

`endif

/* logic/dispatch_pkg.sv */
////////////////////////////////////////
// dispatch stage types
// operation enums, ALU and memory
// payload structs
////////////////////////////////////////

`include "dispatch_params.svh"

package dispatch_pkg;

    // instruction class from decode
    typedef enum logic [1:0] {
        CLASS_NONE  = 2'd0,
        CLASS_ALU   = 2'd1,
        CLASS_LOAD  = 2'd2,
        CLASS_STORE = 2'd3
    } op_class_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // access size, 2'd3 is unused
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        alu_op_e                    op;
        logic [`DATA_WIDTH-1:0]     op1;
        logic [`DATA_WIDTH-1:0]     op2;
        logic [`REG_ADDR_WIDTH-1:0] rd;
    } alu_req_t;

    typedef struct packed {
        logic                        is_load;
        mem_size_e                   size;
        logic                        is_unsigned;
        logic [`DATA_WIDTH-1:0]      addr;
        logic [`WMASK_WIDTH-1:0]     wmask;
        logic [`DATA_WIDTH-1:0]      wdata;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`COMMIT_ID_WIDTH-1:0] commit_id;
        logic                        misaligned;
    } mem_req_t;

endpackage

/* logic/dispatch_decode.sv */
////////////////////////////////////////
// dispatch_decode
// ALU operand select, load/store address,
// write mask, store data, misalignment
////////////////////////////////////////

`timescale 1ns/100ps

`include "dispatch_params.svh"

module dispatch_decode (
    input  dispatch_pkg::op_class_e     dec_class_i,
    input  dispatch_pkg::alu_op_e       dec_alu_op_i,
    input  dispatch_pkg::mem_size_e     dec_mem_size_i,
    input  logic                        dec_mem_unsigned_i,
    input  logic                        dec_use_imm_i,
    input  logic [`DATA_WIDTH-1:0]      dec_imm_i,
    input  logic [`DATA_WIDTH-1:0]      rs1_rdata_i,
    input  logic [`DATA_WIDTH-1:0]      rs2_rdata_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rd_addr_i,

    output dispatch_pkg::alu_req_t      alu_req_o,
    output dispatch_pkg::mem_req_t      mem_req_o,
    output logic                        alloc_req_o
);

    logic                     is_load;
    logic                     is_store;
    logic [`DATA_WIDTH-1:0]   mem_addr;
    logic                     misaligned;
    logic [`WMASK_WIDTH-1:0]  lane_mask;
    logic [`WMASK_WIDTH-1:0]  wmask;
    logic [`DATA_WIDTH-1:0]   wdata;

    assign is_load  = (dec_class_i == dispatch_pkg::CLASS_LOAD);
    assign is_store = (dec_class_i == dispatch_pkg::CLASS_STORE);

    // effective address, rs1 + imm
    assign mem_addr = rs1_rdata_i + dec_imm_i;

    // half needs bit 0 clear, word needs both low bits clear
    always_comb begin
        misaligned = 1'b0;
        if (is_load || is_store) begin
            case (dec_mem_size_i)
                dispatch_pkg::SIZE_HALF: misaligned = mem_addr[0];
                dispatch_pkg::SIZE_WORD: misaligned = (mem_addr[1:0] != 2'b00);
                default:                 misaligned = 1'b0;
            endcase
        end
    end

    // byte lanes touched by the access
    always_comb begin
        case (dec_mem_size_i)
            dispatch_pkg::SIZE_BYTE: lane_mask = `WMASK_WIDTH'(1) << mem_addr[1:0];
            dispatch_pkg::SIZE_HALF: lane_mask = `WMASK_WIDTH'(2'b11) << {mem_addr[1], 1'b0};
            dispatch_pkg::SIZE_WORD: lane_mask = '1;
            default:                 lane_mask = '0;
        endcase
    end

    // only an aligned store writes any lane
    assign wmask = (is_store && !misaligned) ? lane_mask : '0;

    // narrow store data copied to every lane
    always_comb begin
        case (dec_mem_size_i)
            dispatch_pkg::SIZE_BYTE: wdata = {`WMASK_WIDTH{rs2_rdata_i[7:0]}};
            dispatch_pkg::SIZE_HALF: wdata = {(`WMASK_WIDTH / 2){rs2_rdata_i[15:0]}};
            default:                 wdata = rs2_rdata_i;
        endcase
    end

    // ALU payload
    always_comb begin
        alu_req_o.op  = dec_alu_op_i;
        alu_req_o.op1 = rs1_rdata_i;
        alu_req_o.op2 = dec_use_imm_i ? dec_imm_i : rs2_rdata_i;
        alu_req_o.rd  = rd_addr_i;
    end

    // memory payload, commit id is filled in at the top level
    always_comb begin
        mem_req_o.is_load     = is_load;
        mem_req_o.size        = dec_mem_size_i;
        mem_req_o.is_unsigned = dec_mem_unsigned_i;
        mem_req_o.addr        = mem_addr;
        mem_req_o.wmask       = wmask;
        mem_req_o.wdata       = wdata;
        mem_req_o.rd          = rd_addr_i;
        mem_req_o.commit_id   = '0;
        mem_req_o.misaligned  = misaligned;
    end

    // a misaligned load traps and never writes back
    assign alloc_req_o = is_load && !misaligned;

endmodule

/* logic/hazard_unit.sv */
////////////////////////////////////////
// hazard_unit
// load scoreboard, commit id counter
// and the dispatch stall decision
////////////////////////////////////////

`timescale 1ns/100ps

`include "dispatch_params.svh"

module hazard_unit (
    input  logic                        clk,
    input  logic                        rst_n_i,

    input  logic                        inst_valid_i,
    input  dispatch_pkg::op_class_e     dec_class_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rs1_addr_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rs2_addr_i,
    input  logic                        rs1_re_i,
    input  logic                        rs2_re_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rd_addr_i,
    input  logic                        alloc_req_i,
    input  logic                        accept_i,

    // writeback retires one load per cycle
    input  logic                        commit_valid_i,
    input  logic [`COMMIT_ID_WIDTH-1:0] commit_id_i,

    output logic                        hazard_stall_o,
    output logic [`COMMIT_ID_WIDTH-1:0] commit_id_o
);

    localparam int ENTRIES = 1 << `COMMIT_ID_WIDTH;

    logic [ENTRIES-1:0]          busy_q;
    logic [`REG_ADDR_WIDTH-1:0]  rd_q [ENTRIES];
    logic [`COMMIT_ID_WIDTH-1:0] next_id_q;

    logic writes_rd;
    logic raw_hit;
    logic waw_hit;
    logic full_hit;
    logic alloc_fire;

    assign writes_rd = (dec_class_i == dispatch_pkg::CLASS_ALU) ||
                       (dec_class_i == dispatch_pkg::CLASS_LOAD);

    // compare sources and destination against every pending load
    always_comb begin
        raw_hit = 1'b0;
        waw_hit = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            // x0 is never a real dependency
            if (busy_q[i] && (rd_q[i] != '0)) begin
                if (rs1_re_i && (rs1_addr_i == rd_q[i])) begin
                    raw_hit = 1'b1;
                end
                if (rs2_re_i && (rs2_addr_i == rd_q[i])) begin
                    raw_hit = 1'b1;
                end
                if (writes_rd && (rd_addr_i == rd_q[i])) begin
                    waw_hit = 1'b1;
                end
            end
        end
    end

    // no free id for a new load
    assign full_hit = alloc_req_i && busy_q[next_id_q];

    // uses registered state only, a commit frees the entry next cycle
    assign hazard_stall_o = inst_valid_i && (raw_hit || waw_hit || full_hit);

    assign alloc_fire  = accept_i && alloc_req_i;
    assign commit_id_o = next_id_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= '0;
            next_id_q <= '0;
        end else begin
            // stray commit for an idle entry is dropped
            if (commit_valid_i && busy_q[commit_id_i]) begin
                busy_q[commit_id_i] <= 1'b0;
            end
            if (alloc_fire) begin
                busy_q[next_id_q] <= 1'b1;
                // wraps after the last entry
                next_id_q <= next_id_q + 1'b1;
            end
        end
    end

    // destination of each pending load
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[next_id_q] <= rd_addr_i;
        end
    end

endmodule

/* logic/dispatch_pipe_reg.sv */
////////////////////////////////////////
// dispatch_pipe_reg
// one stage register with valid bit,
// hold under back-pressure
////////////////////////////////////////

`timescale 1ns/100ps

module dispatch_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     hold_i,
    input  logic     load_i,
    input  payload_t data_i,

    output logic     valid_o,
    output payload_t data_o
);

    // valid drops to a bubble when nothing is loaded
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= load_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i && load_i) begin
            data_o <= data_i;
        end
    end

endmodule

/* logic/dispatch_top.sv */
////////////////////////////////////////
// dispatch_top
// decode logic, hazard unit and the
// ALU and memory output registers
////////////////////////////////////////

`timescale 1ns/100ps

`include "dispatch_params.svh"

module dispatch_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        stall_i,

    // decoded instruction
    input  logic                        inst_valid_i,
    input  dispatch_pkg::op_class_e     dec_class_i,
    input  dispatch_pkg::alu_op_e       dec_alu_op_i,
    input  dispatch_pkg::mem_size_e     dec_mem_size_i,
    input  logic                        dec_mem_unsigned_i,
    input  logic                        dec_use_imm_i,
    input  logic [`DATA_WIDTH-1:0]      dec_imm_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rs1_addr_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rs2_addr_i,
    input  logic                        rs1_re_i,
    input  logic                        rs2_re_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  rd_addr_i,
    input  logic [`DATA_WIDTH-1:0]      rs1_rdata_i,
    input  logic [`DATA_WIDTH-1:0]      rs2_rdata_i,

    // load writeback
    input  logic                        commit_valid_i,
    input  logic [`COMMIT_ID_WIDTH-1:0] commit_id_i,

    output logic                        hazard_stall_o,

    // ALU port
    output logic                        alu_valid_o,
    output dispatch_pkg::alu_op_e       alu_op_o,
    output logic [`DATA_WIDTH-1:0]      alu_op1_o,
    output logic [`DATA_WIDTH-1:0]      alu_op2_o,
    output logic [`REG_ADDR_WIDTH-1:0]  alu_rd_o,

    // load/store port
    output logic                        mem_valid_o,
    output logic                        mem_load_o,
    output dispatch_pkg::mem_size_e     mem_size_o,
    output logic                        mem_unsigned_o,
    output logic [`DATA_WIDTH-1:0]      mem_addr_o,
    output logic [`WMASK_WIDTH-1:0]     mem_wmask_o,
    output logic [`DATA_WIDTH-1:0]      mem_wdata_o,
    output logic [`REG_ADDR_WIDTH-1:0]  mem_rd_o,
    output logic [`COMMIT_ID_WIDTH-1:0] mem_commit_id_o,
    output logic                        mem_misaligned_o
);

    dispatch_pkg::alu_req_t      alu_req;
    dispatch_pkg::mem_req_t      mem_req;
    dispatch_pkg::mem_req_t      mem_req_id;
    dispatch_pkg::alu_req_t      alu_q;
    dispatch_pkg::mem_req_t      mem_q;
    logic                        alloc_req;
    logic [`COMMIT_ID_WIDTH-1:0] next_commit_id;
    logic                        accept;
    logic                        alu_load;
    logic                        mem_load;

    assign accept   = inst_valid_i && !hazard_stall_o && !stall_i;
    assign alu_load = accept && (dec_class_i == dispatch_pkg::CLASS_ALU);
    assign mem_load = accept && ((dec_class_i == dispatch_pkg::CLASS_LOAD) ||
                                 (dec_class_i == dispatch_pkg::CLASS_STORE));

    // every memory op carries the current id
    always_comb begin
        mem_req_id           = mem_req;
        mem_req_id.commit_id = next_commit_id;
    end

    dispatch_decode u_dispatch_decode (
        .dec_class_i       (dec_class_i),
        .dec_alu_op_i      (dec_alu_op_i),
        .dec_mem_size_i    (dec_mem_size_i),
        .dec_mem_unsigned_i(dec_mem_unsigned_i),
        .dec_use_imm_i     (dec_use_imm_i),
        .dec_imm_i         (dec_imm_i),
        .rs1_rdata_i       (rs1_rdata_i),
        .rs2_rdata_i       (rs2_rdata_i),
        .rd_addr_i         (rd_addr_i),
        .alu_req_o         (alu_req),
        .mem_req_o         (mem_req),
        .alloc_req_o       (alloc_req)
    );

    hazard_unit u_hazard_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .dec_class_i   (dec_class_i),
        .rs1_addr_i    (rs1_addr_i),
        .rs2_addr_i    (rs2_addr_i),
        .rs1_re_i      (rs1_re_i),
        .rs2_re_i      (rs2_re_i),
        .rd_addr_i     (rd_addr_i),
        .alloc_req_i   (alloc_req),
        .accept_i      (accept),
        .commit_valid_i(commit_valid_i),
        .commit_id_i   (commit_id_i),
        .hazard_stall_o(hazard_stall_o),
        .commit_id_o   (next_commit_id)
    );

    dispatch_pipe_reg #(
        .payload_t(dispatch_pkg::alu_req_t)
    ) u_alu_reg (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .hold_i (stall_i),
        .load_i (alu_load),
        .data_i (alu_req),
        .valid_o(alu_valid_o),
        .data_o (alu_q)
    );

    dispatch_pipe_reg #(
        .payload_t(dispatch_pkg::mem_req_t)
    ) u_mem_reg (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .hold_i (stall_i),
        .load_i (mem_load),
        .data_i (mem_req_id),
        .valid_o(mem_valid_o),
        .data_o (mem_q)
    );

    assign alu_op_o  = alu_q.op;
    assign alu_op1_o = alu_q.op1;
    assign alu_op2_o = alu_q.op2;
    assign alu_rd_o  = alu_q.rd;

    assign mem_load_o       = mem_q.is_load;
    assign mem_size_o       = mem_q.size;
    assign mem_unsigned_o   = mem_q.is_unsigned;
    assign mem_addr_o       = mem_q.addr;
    assign mem_wmask_o      = mem_q.wmask;
    assign mem_wdata_o      = mem_q.wdata;
    assign mem_rd_o         = mem_q.rd;
    assign mem_commit_id_o  = mem_q.commit_id;
    assign mem_misaligned_o = mem_q.misaligned;

endmodule

/* dv/dispatch_tb.sv */
////////////////////////////////////////
// testbench for the dispatch stage
// clock, reset, xorshift stimulus,
// scoreboard model, checks, timeout
////////////////////////////////////////

`timescale 1ns/100ps

`include "dispatch_params.svh"

module dispatch_tb;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 4 + 100;
    localparam int ENTRIES        = 1 << `COMMIT_ID_WIDTH;

    logic                        clk = 1'b0;
    logic                        rst_n_i;
    logic                        stall_i;
    logic                        inst_valid_i;
    dispatch_pkg::op_class_e     dec_class_i;
    dispatch_pkg::alu_op_e       dec_alu_op_i;
    dispatch_pkg::mem_size_e     dec_mem_size_i;
    logic                        dec_mem_unsigned_i;
    logic                        dec_use_imm_i;
    logic [`DATA_WIDTH-1:0]      dec_imm_i;
    logic [`REG_ADDR_WIDTH-1:0]  rs1_addr_i;
    logic [`REG_ADDR_WIDTH-1:0]  rs2_addr_i;
    logic                        rs1_re_i;
    logic                        rs2_re_i;
    logic [`REG_ADDR_WIDTH-1:0]  rd_addr_i;
    logic [`DATA_WIDTH-1:0]      rs1_rdata_i;
    logic [`DATA_WIDTH-1:0]      rs2_rdata_i;
    logic                        commit_valid_i;
    logic [`COMMIT_ID_WIDTH-1:0] commit_id_i;

    logic                        hazard_stall_o;
    logic                        alu_valid_o;
    dispatch_pkg::alu_op_e       alu_op_o;
    logic [`DATA_WIDTH-1:0]      alu_op1_o;
    logic [`DATA_WIDTH-1:0]      alu_op2_o;
    logic [`REG_ADDR_WIDTH-1:0]  alu_rd_o;
    logic                        mem_valid_o;
    logic                        mem_load_o;
    dispatch_pkg::mem_size_e     mem_size_o;
    logic                        mem_unsigned_o;
    logic [`DATA_WIDTH-1:0]      mem_addr_o;
    logic [`WMASK_WIDTH-1:0]     mem_wmask_o;
    logic [`DATA_WIDTH-1:0]      mem_wdata_o;
    logic [`REG_ADDR_WIDTH-1:0]  mem_rd_o;
    logic [`COMMIT_ID_WIDTH-1:0] mem_commit_id_o;
    logic                        mem_misaligned_o;

    // reference scoreboard and id counter
    logic                        m_busy [ENTRIES];
    logic [`REG_ADDR_WIDTH-1:0]  m_rd [ENTRIES];
    logic [`COMMIT_ID_WIDTH-1:0] m_next;

    dispatch_pkg::alu_req_t pred_alu;
    dispatch_pkg::alu_req_t exp_alu;
    dispatch_pkg::mem_req_t pred_mem;
    dispatch_pkg::mem_req_t exp_mem;
    logic        pred_alloc;
    logic        exp_alu_valid;
    logic        exp_mem_valid;
    logic        exp_stall;
    logic        accept_now;
    logic        pending;
    logic [31:0] rng_state = 32'd56;
    int          errs [4];
    int          accepted_count;
    int          cycle_count;

    always #20 clk = ~clk;

    dispatch_top uut (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .inst_valid_i      (inst_valid_i),
        .dec_class_i       (dec_class_i),
        .dec_alu_op_i      (dec_alu_op_i),
        .dec_mem_size_i    (dec_mem_size_i),
        .dec_mem_unsigned_i(dec_mem_unsigned_i),
        .dec_use_imm_i     (dec_use_imm_i),
        .dec_imm_i         (dec_imm_i),
        .rs1_addr_i        (rs1_addr_i),
        .rs2_addr_i        (rs2_addr_i),
        .rs1_re_i          (rs1_re_i),
        .rs2_re_i          (rs2_re_i),
        .rd_addr_i         (rd_addr_i),
        .rs1_rdata_i       (rs1_rdata_i),
        .rs2_rdata_i       (rs2_rdata_i),
        .commit_valid_i    (commit_valid_i),
        .commit_id_i       (commit_id_i),
        .hazard_stall_o    (hazard_stall_o),
        .alu_valid_o       (alu_valid_o),
        .alu_op_o          (alu_op_o),
        .alu_op1_o         (alu_op1_o),
        .alu_op2_o         (alu_op2_o),
        .alu_rd_o          (alu_rd_o),
        .mem_valid_o       (mem_valid_o),
        .mem_load_o        (mem_load_o),
        .mem_size_o        (mem_size_o),
        .mem_unsigned_o    (mem_unsigned_o),
        .mem_addr_o        (mem_addr_o),
        .mem_wmask_o       (mem_wmask_o),
        .mem_wdata_o       (mem_wdata_o),
        .mem_rd_o          (mem_rd_o),
        .mem_commit_id_o   (mem_commit_id_o),
        .mem_misaligned_o  (mem_misaligned_o)
    );

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_field(input string test, input logic [31:0] expected,
                               input logic [31:0] actual, input int kind);
        assert (actual === expected) else begin
            $display("Error: %s expected %0h actual %0h", test, expected, actual);
            errs[kind] = errs[kind] + 1;
        end
    endtask

    // expected payloads for the instruction now on the inputs
    task automatic predict_payloads();
        logic [`DATA_WIDTH-1:0]  addr;
        logic                    mis;
        logic [`WMASK_WIDTH-1:0] mask;
        addr = rs1_rdata_i + dec_imm_i;
        mis  = ((dec_mem_size_i == dispatch_pkg::SIZE_HALF) && addr[0]) ||
               ((dec_mem_size_i == dispatch_pkg::SIZE_WORD) && (addr[1:0] != 2'b00));
        case (dec_mem_size_i)
            dispatch_pkg::SIZE_BYTE: mask = 4'b0001 << addr[1:0];
            dispatch_pkg::SIZE_HALF: mask = addr[1] ? 4'b1100 : 4'b0011;
            default:                 mask = 4'b1111;
        endcase
        if ((dec_class_i != dispatch_pkg::CLASS_STORE) || mis) begin
            mask = 4'b0000;
        end
        pred_alu.op  = dec_alu_op_i;
        pred_alu.op1 = rs1_rdata_i;
        pred_alu.op2 = dec_use_imm_i ? dec_imm_i : rs2_rdata_i;
        pred_alu.rd  = rd_addr_i;
        pred_mem.is_load     = (dec_class_i == dispatch_pkg::CLASS_LOAD);
        pred_mem.size        = dec_mem_size_i;
        pred_mem.is_unsigned = dec_mem_unsigned_i;
        pred_mem.addr        = addr;
        pred_mem.wmask       = mask;
        case (dec_mem_size_i)
            dispatch_pkg::SIZE_BYTE: pred_mem.wdata = {4{rs2_rdata_i[7:0]}};
            dispatch_pkg::SIZE_HALF: pred_mem.wdata = {2{rs2_rdata_i[15:0]}};
            default:                 pred_mem.wdata = rs2_rdata_i;
        endcase
        pred_mem.rd         = rd_addr_i;
        pred_mem.commit_id  = m_next;
        pred_mem.misaligned = mis;
        pred_alloc = (dec_class_i == dispatch_pkg::CLASS_LOAD) && !mis;
    endtask

    function automatic logic predict_stall();
        logic hit;
        logic writes_rd;
        hit = 1'b0;
        writes_rd = (dec_class_i == dispatch_pkg::CLASS_ALU) ||
                    (dec_class_i == dispatch_pkg::CLASS_LOAD);
        for (int i = 0; i < ENTRIES; i++) begin
            // pending load to x0 blocks nothing
            if (m_busy[i] && (m_rd[i] != '0)) begin
                if (rs1_re_i && (rs1_addr_i == m_rd[i])) begin
                    hit = 1'b1;
                end
                if (rs2_re_i && (rs2_addr_i == m_rd[i])) begin
                    hit = 1'b1;
                end
                if (writes_rd && (rd_addr_i == m_rd[i])) begin
                    hit = 1'b1;
                end
            end
        end
        if (pred_alloc && m_busy[m_next]) begin
            hit = 1'b1;
        end
        return inst_valid_i && hit;
    endfunction

    task automatic new_instruction();
        logic [31:0] r;
        logic [31:0] imm;
        r   = next_rand();
        imm = next_rand();
        case (r[1:0])
            2'd2:    dec_class_i = dispatch_pkg::CLASS_LOAD;
            2'd3:    dec_class_i = dispatch_pkg::CLASS_STORE;
            default: dec_class_i = dispatch_pkg::CLASS_ALU;
        endcase
        dec_alu_op_i   = dispatch_pkg::alu_op_e'(r[4:2]);
        dec_mem_size_i = (r[6:5] == 2'd3) ? dispatch_pkg::SIZE_WORD
                                          : dispatch_pkg::mem_size_e'(r[6:5]);
        dec_mem_unsigned_i = r[7];
        dec_use_imm_i      = r[8];
        // pool of x0..x7 so conflicts are frequent
        rs1_addr_i = `REG_ADDR_WIDTH'(r[11:9]);
        rs2_addr_i = `REG_ADDR_WIDTH'(r[14:12]);
        rd_addr_i  = `REG_ADDR_WIDTH'(r[17:15]);
        // some ALU ops have no register source, as lui
        rs1_re_i   = (dec_class_i != dispatch_pkg::CLASS_ALU) || (r[20:18] != 3'd0);
        rs2_re_i   = (dec_class_i == dispatch_pkg::CLASS_STORE) ||
                     ((dec_class_i == dispatch_pkg::CLASS_ALU) && !r[8]);
        // small signed immediate keeps the low address bits random
        dec_imm_i    = {{20{imm[11]}}, imm[11:0]};
        rs1_rdata_i  = next_rand();
        rs2_rdata_i  = next_rand();
        inst_valid_i = 1'b1;
    endtask

    // model state after a rising edge
    task automatic update_model();
        if (!stall_i) begin
            exp_alu_valid = accept_now && (dec_class_i == dispatch_pkg::CLASS_ALU);
            if (exp_alu_valid) begin
                exp_alu = pred_alu;
            end
            exp_mem_valid = accept_now && ((dec_class_i == dispatch_pkg::CLASS_LOAD) ||
                                           (dec_class_i == dispatch_pkg::CLASS_STORE));
            if (exp_mem_valid) begin
                exp_mem = pred_mem;
            end
        end
        if (commit_valid_i && m_busy[commit_id_i]) begin
            m_busy[commit_id_i] = 1'b0;
        end
        if (accept_now && pred_alloc) begin
            m_busy[m_next] = 1'b1;
            m_rd[m_next]   = rd_addr_i;
            m_next         = m_next + 1'b1;
        end
        if (accept_now) begin
            pending        = 1'b0;
            accepted_count = accepted_count + 1;
        end
    endtask

    task automatic check_outputs();
        check_field("alu_port valid", 32'(exp_alu_valid), 32'(alu_valid_o), 1);
        if (exp_alu_valid) begin
            check_field("alu_port op", 32'(exp_alu.op), 32'(alu_op_o), 1);
            check_field("alu_port op1", exp_alu.op1, alu_op1_o, 1);
            check_field("alu_port op2", exp_alu.op2, alu_op2_o, 1);
            check_field("alu_port rd", 32'(exp_alu.rd), 32'(alu_rd_o), 1);
        end
        check_field("mem_port valid", 32'(exp_mem_valid), 32'(mem_valid_o), 2);
        if (exp_mem_valid) begin
            check_field("mem_port load", 32'(exp_mem.is_load), 32'(mem_load_o), 2);
            check_field("mem_port size", 32'(exp_mem.size), 32'(mem_size_o), 2);
            check_field("mem_port unsigned", 32'(exp_mem.is_unsigned), 32'(mem_unsigned_o), 2);
            check_field("mem_port addr", exp_mem.addr, mem_addr_o, 2);
            check_field("mem_port wmask", 32'(exp_mem.wmask), 32'(mem_wmask_o), 2);
            check_field("mem_port wdata", exp_mem.wdata, mem_wdata_o, 2);
            check_field("mem_port rd", 32'(exp_mem.rd), 32'(mem_rd_o), 2);
            check_field("mem_port commit_id", 32'(exp_mem.commit_id), 32'(mem_commit_id_o), 2);
            check_field("mem_port misaligned", 32'(exp_mem.misaligned),
                        32'(mem_misaligned_o), 2);
        end
    endtask

    // output checks and the prediction for the next edge
    task automatic check_cycle();
        check_outputs();
        predict_payloads();
        exp_stall = predict_stall();
        check_field("hazard_stall", 32'(exp_stall), 32'(hazard_stall_o), 0);
        accept_now = inst_valid_i && !exp_stall && !stall_i;
    endtask

    // one clock of model update, drive and falling edge checks
    task automatic run_cycle(input logic issue);
        logic [31:0] r;
        int          idx;
        @(posedge clk);
        update_model();
        #2;
        r = next_rand();
        if (!pending) begin
            if (issue && (r[13:11] != 3'd0)) begin
                new_instruction();
                pending = 1'b1;
            end else begin
                inst_valid_i = 1'b0;
            end
        end
        // writeback returns one pending load at random
        commit_valid_i = 1'b0;
        if (r[0]) begin
            for (int k = 0; k < ENTRIES; k++) begin
                idx = (r[2:1] + k) % ENTRIES;
                if (m_busy[idx] && !commit_valid_i) begin
                    commit_valid_i = 1'b1;
                    commit_id_i    = idx[`COMMIT_ID_WIDTH-1:0];
                end
            end
        end else if (r[5:3] == 3'd0) begin
            // random id that may name a free entry
            commit_valid_i = 1'b1;
            commit_id_i    = r[7:6];
        end
        stall_i = (r[10:8] == 3'd0);
        @(negedge clk);
        check_cycle();
    endtask

    // four aligned loads take every id so the fifth must wait
    task automatic load_burst();
        for (int n = 0; n <= ENTRIES; n++) begin
            @(posedge clk);
            update_model();
            #2;
            dec_class_i    = dispatch_pkg::CLASS_LOAD;
            dec_mem_size_i = dispatch_pkg::SIZE_BYTE;
            dec_imm_i      = '0;
            rs1_addr_i     = '0;
            rs1_re_i       = 1'b1;
            rs2_re_i       = 1'b0;
            rd_addr_i      = `REG_ADDR_WIDTH'(n + 1);
            rs1_rdata_i    = next_rand();
            rs2_rdata_i    = next_rand();
            inst_valid_i   = 1'b1;
            pending        = 1'b1;
            commit_valid_i = 1'b0;
            stall_i        = 1'b0;
            @(negedge clk);
            check_cycle();
        end
        // no writeback yet so all four ids are still busy
        check_field("full table stall", 32'd1, 32'(hazard_stall_o), 0);
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: dispatch run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        rst_n_i            = 1'b0;
        stall_i            = 1'b0;
        inst_valid_i       = 1'b0;
        dec_class_i        = dispatch_pkg::CLASS_NONE;
        dec_alu_op_i       = dispatch_pkg::ALU_ADD;
        dec_mem_size_i     = dispatch_pkg::SIZE_BYTE;
        dec_mem_unsigned_i = 1'b0;
        dec_use_imm_i      = 1'b0;
        dec_imm_i          = '0;
        rs1_addr_i         = '0;
        rs2_addr_i         = '0;
        rs1_re_i           = 1'b0;
        rs2_re_i           = 1'b0;
        rd_addr_i          = '0;
        rs1_rdata_i        = '0;
        rs2_rdata_i        = '0;
        commit_valid_i     = 1'b0;
        commit_id_i        = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            m_busy[i] = 1'b0;
            m_rd[i]   = '0;
        end
        for (int i = 0; i < 4; i++) begin
            errs[i] = 0;
        end
        m_next         = '0;
        pred_alloc     = 1'b0;
        exp_alu_valid  = 1'b0;
        exp_mem_valid  = 1'b0;
        accept_now     = 1'b0;
        pending        = 1'b0;
        accepted_count = 0;
        cycle_count    = 0;
        repeat (4) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk);
        // idle after reset
        check_field("reset alu_valid", 32'd0, 32'(alu_valid_o), 3);
        check_field("reset mem_valid", 32'd0, 32'(mem_valid_o), 3);
        check_field("reset hazard_stall", 32'd0, 32'(hazard_stall_o), 3);
        load_burst();
        while (accepted_count < NUM_INSTR) begin
            run_cycle(1'b1);
        end
        // drain so the outputs fall back to bubbles
        repeat (6) run_cycle(1'b0);
        $display("error counts: stall %0d, alu port %0d, mem port %0d, reset %0d",
                 errs[0], errs[1], errs[2], errs[3]);
        if ((errs[0] + errs[1] + errs[2] + errs[3]) == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/dispatch_pkg.sv
logic/dispatch_decode.sv
logic/hazard_unit.sv
logic/dispatch_pipe_reg.sv
logic/dispatch_top.sv
dv/dispatch_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the dispatch testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module dispatch_tb -o dispatch_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/dispatch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
